// ==== rv_exec.f ====
+incdir+dv
verilog/rv_exec_pkg.sv
verilog/rv_ctrl_if.sv
verilog/rv_decoder.sv
verilog/rv_gpr_file.sv
verilog/rv_alu.sv
verilog/rv_csu.sv
verilog/rv_exu.sv
verilog/rv_exec_top.sv
dv/tb_rv_exec.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the rv_exec testbench with Verilator, pass or fail taken from the log
rm -f sim.log
verilator --binary --timing --assert -f rv_exec.f --top-module tb_rv_exec \
  -Mdir obj_dir -o tb_rv_exec \
  && ./obj_dir/tb_rv_exec > sim.log 2>&1 \
  || echo "build or simulation did not complete"
cat sim.log 2>/dev/null
grep -q "^NO ERRORS$" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== dv/tb_rv_ref.svh ====
// reference model: shadow registers and CSRs, instruction encoders, Galois LFSR
`ifndef TB_RV_REF_SVH
`define TB_RV_REF_SVH

logic [63:0] ref_gpr [0:31];
logic [63:0] ref_csr [0:3];
logic [31:0] lfsr_state = 32'd90;

task automatic ref_reset();
  for (int i = 0; i < 32; i++) begin
    ref_gpr[i] = '0;
  end
  for (int i = 0; i < 4; i++) begin
    ref_csr[i] = '0;
  end
endtask

// one LFSR step per bit taken
function automatic logic [63:0] rand_bits(input int n);
  logic [63:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'hD000_0001) : (lfsr_state >> 1);
    v = {v[62:0], lfsr_state[0]};
  end
  return v;
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] opc, input int f3, input int f7,
                                      input int rd, input int rs1, input int rs2);
  return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), opc};
endfunction

function automatic logic [31:0] enc_i(input logic [6:0] opc, input int f3, input int rd,
                                      input int rs1, input int imm);
  return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), opc};
endfunction

function automatic logic [31:0] enc_u(input logic [6:0] opc, input int rd, input int imm);
  return {20'(imm), 5'(rd), opc};
endfunction

function automatic logic [31:0] enc_j(input int rd, input int imm);
  logic [20:0] j;
  j = 21'(imm);
  return {j[20], j[10:1], j[11], j[19:12], 5'(rd), OPC_JAL};
endfunction

function automatic int csr_index(input logic [11:0] addr);
  case (addr)
    CSR_MSTATUS: return 0;
    CSR_MTVEC:   return 1;
    CSR_MEPC:    return 2;
    CSR_MCAUSE:  return 3;
    default:     return -1;
  endcase
endfunction

function automatic logic [63:0] alu64(input logic [2:0] f3, input logic alt,
                                      input logic [63:0] a, input logic [63:0] b);
  logic [63:0] r;
  case (f3)
    3'd0: r = alt ? a - b : a + b;
    3'd1: r = a << b[5:0];
    3'd2: r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
    3'd3: r = (a < b) ? 64'd1 : 64'd0;
    3'd4: r = a ^ b;
    3'd5: begin
      if (alt) begin
        r = $signed(a) >>> b[5:0];
      end else begin
        r = a >> b[5:0];
      end
    end
    3'd6: r = a | b;
    default: r = a & b;
  endcase
  return r;
endfunction

// word forms: 32-bit result, sign-extended from bit 31
function automatic logic [63:0] alu32(input logic [2:0] f3, input logic alt,
                                      input logic [31:0] a, input logic [31:0] b);
  logic [31:0] r;
  if (f3 == 3'd0) begin
    r = alt ? a - b : a + b;
  end else if (f3 == 3'd1) begin
    r = a << b[4:0];
  end else if (alt) begin
    r = $signed(a) >>> b[4:0];
  end else begin
    r = a >> b[4:0];
  end
  return {{32{r[31]}}, r};
endfunction

function automatic logic [63:0] ref_exec(input logic [31:0] inst, input logic [63:0] pc);
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [2:0]  f3;
  logic [63:0] a;
  logic [63:0] b;
  logic [63:0] imm_i;
  logic [63:0] imm_u;
  logic [63:0] src;
  logic [63:0] res;
  int          idx;
  rd    = inst[11:7];
  rs1   = inst[19:15];
  f3    = inst[14:12];
  a     = ref_gpr[rs1];
  b     = ref_gpr[inst[24:20]];
  imm_i = {{52{inst[31]}}, inst[31:20]};
  imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
  res   = '0;
  case (inst[6:0])
    OPC_OP:            res = alu64(f3, inst[30], a, b);
    OPC_OP_IMM:        res = alu64(f3, inst[30] && f3 == 3'd5, a, imm_i);
    OPC_OP_32:         res = alu32(f3, inst[30], a[31:0], b[31:0]);
    OPC_OP_IMM_32:     res = alu32(f3, inst[30] && f3 == 3'd5, a[31:0], imm_i[31:0]);
    OPC_LUI:           res = imm_u;
    OPC_AUIPC:         res = pc + imm_u;
    OPC_JAL, OPC_JALR: res = pc + 64'd4;
    OPC_SYSTEM: begin
      idx = csr_index(inst[31:20]);
      src = f3[2] ? {59'b0, rs1} : a;
      if (idx >= 0) begin
        res = ref_csr[idx];
        // set and clear with x0 or zimm 0 only read
        if (f3[1:0] == 2'd1) begin
          ref_csr[idx] = src;
        end else if (f3[1:0] == 2'd2 && rs1 != 5'd0) begin
          ref_csr[idx] = res | src;
        end else if (f3[1:0] == 2'd3 && rs1 != 5'd0) begin
          ref_csr[idx] = res & ~src;
        end
      end
    end
    default: res = '0;
  endcase
  if (rd != 5'd0) begin
    ref_gpr[rd] = res;
  end
  return res;
endfunction

`endif

// ==== dv/tb_rv_exec.sv ====
// testbench for the execute path: clock, reset, stimulus table, checks and report
`timescale 1ns/100ps

module tb_rv_exec;
  import rv_exec_pkg::*;

  localparam int K_WB      = 0;
  localparam int K_HALT    = 1;
  localparam int K_ILLEGAL = 2;
  localparam int K_NONE    = 3;
  localparam int K_RESET   = 4;
  localparam int TIMEOUT_CYCLES = 20;

  typedef struct {
    string       name;
    logic [31:0] inst;
    logic [63:0] pc;
    int          kind;
  } test_t;

  logic        i_clk;
  logic        i_rst_n;
  logic        i_valid;
  logic [31:0] i_inst;
  logic [63:0] i_pc;
  logic        o_wb_valid;
  logic [4:0]  o_wb_rd;
  logic [63:0] o_wb_data;
  logic        o_halt;
  logic        o_illegal;

  test_t tests [$];
  int    test_count;
  int    fail_count;
  int    error_count;

  `include "tb_rv_ref.svh"

  rv_exec_top dut0 (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_valid    (i_valid),
    .i_inst     (i_inst),
    .i_pc       (i_pc),
    .o_wb_valid (o_wb_valid),
    .o_wb_rd    (o_wb_rd),
    .o_wb_data  (o_wb_data),
    .o_halt     (o_halt),
    .o_illegal  (o_illegal)
  );

  initial begin
    i_clk = 1'b0;
    forever begin
      #2 i_clk = ~i_clk;
    end
  end

  task automatic add_test(input string name, input logic [31:0] inst, input int kind);
    test_t t;
    t.name = name;
    t.inst = inst;
    t.pc   = rand_bits(62) << 2;
    t.kind = kind;
    tests.push_back(t);
  endtask

  // wide random value in rd, x31 as scratch
  task automatic load_random(input int rd);
    add_test($sformatf("lui_x%0d", rd), enc_u(OPC_LUI, rd, int'(rand_bits(20))), K_WB);
    add_test($sformatf("slli_x%0d", rd), enc_i(OPC_OP_IMM, 1, rd, rd, 28), K_WB);
    add_test("lui_x31", enc_u(OPC_LUI, 31, int'(rand_bits(20))), K_WB);
    add_test($sformatf("xor_x%0d", rd), enc_r(OPC_OP, 4, 0, rd, rd, 31), K_WB);
    add_test($sformatf("addi_x%0d", rd), enc_i(OPC_OP_IMM, 0, rd, rd, int'(rand_bits(12))), K_WB);
  endtask

  task automatic build_table();
    string op_names [8];
    string imm_names [8];
    int    imm;
    op_names  = '{"add", "sll", "slt", "sltu", "xor", "srl", "or", "and"};
    imm_names = '{"addi", "slli", "slti", "sltiu", "xori", "srli", "ori", "andi"};
    add_test("add_x2_x1_x0", enc_r(OPC_OP, 0, 0, 2, 1, 0), K_WB);
    for (int r = 1; r <= 4; r++) begin
      add_test($sformatf("addi_x%0d", r), enc_i(OPC_OP_IMM, 0, r, 0, int'(rand_bits(12))), K_WB);
    end
    load_random(5);
    load_random(6);
    // each result feeds rs1 of the next
    for (int f = 0; f < 8; f++) begin
      add_test(op_names[f], enc_r(OPC_OP, f, 0, 7 + f, (f == 0) ? 5 : 6 + f,
                                  (f % 2 == 0) ? 6 : 3), K_WB);
    end
    add_test("sub", enc_r(OPC_OP, 0, 32, 15, 14, 5), K_WB);
    add_test("sra", enc_r(OPC_OP, 5, 32, 16, 5, 1), K_WB);
    for (int f = 0; f < 8; f++) begin
      imm = (f == 1 || f == 5) ? int'(rand_bits(6)) : int'(rand_bits(12));
      add_test(imm_names[f], enc_i(OPC_OP_IMM, f, (f % 2 == 0) ? 17 : 18, 6, imm), K_WB);
    end
    add_test("srai", enc_i(OPC_OP_IMM, 5, 19, 5, 1024 + int'(rand_bits(6))), K_WB);
    load_random(20);
    load_random(21);
    add_test("addw", enc_r(OPC_OP_32, 0, 0, 22, 20, 21), K_WB);
    add_test("subw", enc_r(OPC_OP_32, 0, 32, 23, 20, 21), K_WB);
    add_test("sllw", enc_r(OPC_OP_32, 1, 0, 24, 20, 21), K_WB);
    add_test("srlw", enc_r(OPC_OP_32, 5, 0, 25, 20, 21), K_WB);
    add_test("sraw", enc_r(OPC_OP_32, 5, 32, 26, 20, 21), K_WB);
    add_test("addiw", enc_i(OPC_OP_IMM_32, 0, 27, 21, int'(rand_bits(12))), K_WB);
    add_test("lui", enc_u(OPC_LUI, 9, int'(rand_bits(20))), K_WB);
    add_test("auipc", enc_u(OPC_AUIPC, 10, int'(rand_bits(20))), K_WB);
    add_test("jal", enc_j(1, int'(rand_bits(20)) * 2), K_WB);
    add_test("jalr", enc_i(OPC_JALR, 0, 11, 5, int'(rand_bits(12))), K_WB);
    add_test("lui_x0", enc_u(OPC_LUI, 0, int'(rand_bits(20))), K_WB);
    add_test("add_x12_x0_x0", enc_r(OPC_OP, 0, 0, 12, 0, 0), K_WB);
    add_test("csrrw_mstatus", enc_i(OPC_SYSTEM, 1, 13, 20, CSR_MSTATUS), K_WB);
    add_test("csrrs_mstatus", enc_i(OPC_SYSTEM, 2, 14, 21, CSR_MSTATUS), K_WB);
    add_test("csrrc_mstatus", enc_i(OPC_SYSTEM, 3, 15, 5, CSR_MSTATUS), K_WB);
    add_test("csrr_mstatus", enc_i(OPC_SYSTEM, 2, 16, 0, CSR_MSTATUS), K_WB);
    add_test("csrrwi_mtvec", enc_i(OPC_SYSTEM, 5, 16, int'(rand_bits(5)), CSR_MTVEC), K_WB);
    add_test("csrrsi_mtvec_0", enc_i(OPC_SYSTEM, 6, 17, 0, CSR_MTVEC), K_WB);
    add_test("csrrci_mtvec", enc_i(OPC_SYSTEM, 7, 18, int'(rand_bits(5)), CSR_MTVEC), K_WB);
    add_test("csrr_mtvec", enc_i(OPC_SYSTEM, 2, 19, 0, CSR_MTVEC), K_WB);
    add_test("csrrw_mepc", enc_i(OPC_SYSTEM, 1, 23, 6, CSR_MEPC), K_WB);
    add_test("csrrc_mepc_x0", enc_i(OPC_SYSTEM, 3, 24, 0, CSR_MEPC), K_WB);
    add_test("csrrsi_mcause", enc_i(OPC_SYSTEM, 6, 25, int'(rand_bits(5)) | 1, CSR_MCAUSE), K_WB);
    add_test("csrr_mcause", enc_i(OPC_SYSTEM, 2, 26, 0, CSR_MCAUSE), K_WB);
    add_test("ebreak", 32'h0010_0073, K_HALT);
    add_test("addi_halted", enc_i(OPC_OP_IMM, 0, 1, 0, 1), K_NONE);
    add_test("reset", 32'h0, K_RESET);
    add_test("csrrw_bad_addr", enc_i(OPC_SYSTEM, 1, 1, 0, 12'h7c0), K_ILLEGAL);
    add_test("addi_illegal", enc_i(OPC_OP_IMM, 0, 2, 0, 5), K_NONE);
  endtask

  task automatic apply_reset();
    i_rst_n = 1'b0;
    i_valid = 1'b0;
    repeat (4) @(posedge i_clk);
    @(negedge i_clk);
    i_rst_n = 1'b1;
  endtask

  task automatic compare_value(input string name, input string what,
                               input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      $display("error %s %s: expected %h, actual %h", name, what, exp, act);
      error_count++;
    end
  endtask

  function automatic bit flag_value(input int kind);
    case (kind)
      K_HALT:    return o_halt;
      K_ILLEGAL: return o_illegal;
      default:   return o_wb_valid;
    endcase
  endfunction

  // expected one cycle after issue; a later arrival is an error too
  task automatic wait_for_flag(input string name, input int kind);
    int cyc;
    cyc = 0;
    while (!flag_value(kind) && cyc < TIMEOUT_CYCLES) begin
      i_valid = 1'b0;
      @(negedge i_clk);
      cyc++;
    end
    assert (flag_value(kind)) else begin
      $display("%s: timed out, the expected status or write-back never came", name);
      error_count++;
    end
    assert (cyc == 0 || !flag_value(kind)) else begin
      $display("%s: response came %0d cycles late", name, cyc);
      error_count++;
    end
  endtask

  task automatic check_idle(input string name);
    compare_value(name, "o_wb_valid", 64'd0, 64'(o_wb_valid));
    compare_value(name, "o_halt", 64'd0, 64'(o_halt));
    compare_value(name, "o_illegal", 64'd0, 64'(o_illegal));
  endtask

  task automatic run_test(input test_t t);
    logic [63:0] exp;
    int          errs_before;
    errs_before = error_count;
    exp = '0;
    if (t.kind == K_RESET) begin
      apply_reset();
      ref_reset();
      check_idle(t.name);
    end else begin
      if (t.kind == K_WB) begin
        exp = ref_exec(t.inst, t.pc);
      end
      i_valid = 1'b1;
      i_inst  = t.inst;
      i_pc    = t.pc;
      @(negedge i_clk);
      if (t.kind != K_NONE) begin
        wait_for_flag(t.name, t.kind);
      end
      if (t.kind == K_WB) begin
        compare_value(t.name, "o_wb_rd", 64'(t.inst[11:7]), 64'(o_wb_rd));
        compare_value(t.name, "o_wb_data", exp, o_wb_data);
      end else begin
        compare_value(t.name, "o_wb_valid", 64'd0, 64'(o_wb_valid));
      end
    end
    test_count++;
    if (error_count != errs_before) begin
      fail_count++;
    end
    $display("%-16s %s", t.name, (error_count == errs_before) ? "ok" : "failed");
  endtask

  initial begin
    i_rst_n     = 1'b0;
    i_valid     = 1'b0;
    i_inst      = '0;
    i_pc        = '0;
    test_count  = 0;
    fail_count  = 0;
    error_count = 0;
    ref_reset();
    build_table();
    apply_reset();
    check_idle("reset_state");
    test_count++;
    fail_count = (error_count != 0) ? 1 : 0;
    $display("%-16s %s", "reset_state", (error_count == 0) ? "ok" : "failed");
    foreach (tests[i]) begin
      run_test(tests[i]);
    end
    i_valid = 1'b0;
    @(negedge i_clk);
    $display("tests %0d, failed %0d, errors %0d", test_count, fail_count, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== verilog/rv_exec_top.sv ====
// top level: decoder, general register file and execute unit
`timescale 1ns/100ps

module rv_exec_top (
  input  logic                         i_clk,
  input  logic                         i_rst_n,
  input  logic                         i_valid,
  input  logic [31:0]                  i_inst,
  input  logic [rv_exec_pkg::XLEN-1:0] i_pc,
  output logic                         o_wb_valid,
  output logic [4:0]                   o_wb_rd,
  output logic [rv_exec_pkg::XLEN-1:0] o_wb_data,
  output logic                         o_halt,
  output logic                         o_illegal
);
  import rv_exec_pkg::*;

  logic [4:0]      rs1;
  logic [4:0]      rs2;
  logic [XLEN-1:0] rs1data;
  logic [XLEN-1:0] rs2data;
  logic            gpr_we;
  logic [4:0]      gpr_waddr;
  logic [XLEN-1:0] gpr_wdata;

  rv_ctrl_if ctrl ();

  rv_decoder u_dec (
    .i_inst  (i_inst),
    .i_valid (i_valid),
    .o_rs1   (rs1),
    .o_rs2   (rs2),
    .ctrl    (ctrl.dec)
  );

  rv_gpr_file u_gpr (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .o_rdata1 (rs1data),
    .o_rdata2 (rs2data),
    .i_we     (gpr_we),
    .i_waddr  (gpr_waddr),
    .i_wdata  (gpr_wdata)
  );

  rv_exu u_exu (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .ctrl        (ctrl.exu),
    .i_pc        (i_pc),
    .i_rs1data   (rs1data),
    .i_rs2data   (rs2data),
    .o_gpr_we    (gpr_we),
    .o_gpr_waddr (gpr_waddr),
    .o_gpr_wdata (gpr_wdata),
    .o_wb_valid  (o_wb_valid),
    .o_wb_rd     (o_wb_rd),
    .o_wb_data   (o_wb_data),
    .o_halt      (o_halt),
    .o_illegal   (o_illegal)
  );

endmodule

// ==== verilog/rv_exu.sv ====
// execute unit: operand select, word cut, ALU and CSU, write-back and sticky status
`timescale 1ns/100ps

module rv_exu (
  input  logic                         i_clk,
  input  logic                         i_rst_n,
  rv_ctrl_if.exu                       ctrl,
  input  logic [rv_exec_pkg::XLEN-1:0] i_pc,
  input  logic [rv_exec_pkg::XLEN-1:0] i_rs1data,
  input  logic [rv_exec_pkg::XLEN-1:0] i_rs2data,
  output logic                         o_gpr_we,
  output logic [4:0]                   o_gpr_waddr,
  output logic [rv_exec_pkg::XLEN-1:0] o_gpr_wdata,
  output logic                         o_wb_valid,
  output logic [4:0]                   o_wb_rd,
  output logic [rv_exec_pkg::XLEN-1:0] o_wb_data,
  output logic                         o_halt,
  output logic                         o_illegal
);
  import rv_exec_pkg::*;

  logic [XLEN-1:0] src1;
  logic [XLEN-1:0] src2;
  logic [XLEN-1:0] imm;
  logic [XLEN-1:0] src_a;
  logic [XLEN-1:0] src_b;
  logic [XLEN-1:0] alu_result;
  logic [XLEN-1:0] csr_old;
  logic            csr_addr_ok;
  logic            is_csr;
  logic            accept;
  logic            bad;
  logic            commit;

  // word forms see only the low 32 bits, zero-extended
  assign src1 = ctrl.word_cut ? {{(XLEN-32){1'b0}}, i_rs1data[31:0]} : i_rs1data;
  assign src2 = ctrl.word_cut ? {{(XLEN-32){1'b0}}, i_rs2data[31:0]} : i_rs2data;
  assign imm  = ctrl.word_cut ? {{(XLEN-32){1'b0}}, ctrl.imm[31:0]} : ctrl.imm;

  assign src_a = ctrl.src1_pc ? i_pc : src1;

  always_comb begin
    case (ctrl.src2_sel)
      SRC2_RS2:  src_b = src2;
      SRC2_IMM:  src_b = imm;
      SRC2_FOUR: src_b = XLEN'(4);
      default:   src_b = '0;
    endcase
  end

  rv_alu u_alu (
    .i_src_a    (src_a),
    .i_src_b    (src_b),
    .i_alu_op   (ctrl.alu_op),
    .i_word_cut (ctrl.word_cut),
    .o_result   (alu_result)
  );

  // status flags freeze the unit
  assign is_csr = (ctrl.csr_op != CSR_OP_NONE);
  assign accept = ctrl.valid && !o_halt && !o_illegal;
  assign bad    = ctrl.illegal || (is_csr && !csr_addr_ok);
  assign commit = accept && !bad && !ctrl.ebreak;

  rv_csu u_csu (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_we       (commit && is_csr),
    .i_csr_op   (ctrl.csr_op),
    .i_csr_imm  (ctrl.csr_imm),
    .i_csr_addr (ctrl.csr_addr),
    .i_rs1data  (i_rs1data),
    .i_zimm     (ctrl.imm[4:0]),
    .o_old      (csr_old),
    .o_addr_ok  (csr_addr_ok)
  );

  assign o_gpr_we    = commit && ctrl.rd_we;
  assign o_gpr_waddr = ctrl.rd;
  assign o_gpr_wdata = is_csr ? csr_old : alu_result;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_wb_valid <= 1'b0;
      o_halt     <= 1'b0;
      o_illegal  <= 1'b0;
    end else begin
      o_wb_valid <= o_gpr_we;
      if (accept && bad) begin
        o_illegal <= 1'b1;
      end
      if (accept && ctrl.ebreak) begin
        o_halt <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_gpr_we) begin
      o_wb_rd   <= ctrl.rd;
      o_wb_data <= o_gpr_wdata;
    end
  end

  a_no_wb_after_halt: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_halt |-> !o_wb_valid)
    else $error("write-back while halted");

endmodule

// ==== verilog/rv_csu.sv ====
// CSR unit holding mstatus, mtvec, mepc and mcause with read-modify-write
`timescale 1ns/100ps

module rv_csu (
  input  logic                         i_clk,
  input  logic                         i_rst_n,
  input  logic                         i_we,
  input  rv_exec_pkg::csr_op_e         i_csr_op,
  input  logic                         i_csr_imm,
  input  logic [11:0]                  i_csr_addr,
  input  logic [rv_exec_pkg::XLEN-1:0] i_rs1data,
  input  logic [4:0]                   i_zimm,
  output logic [rv_exec_pkg::XLEN-1:0] o_old,
  output logic                         o_addr_ok
);
  import rv_exec_pkg::*;

  logic [XLEN-1:0] mstatus;
  logic [XLEN-1:0] mtvec;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] mcause;
  logic [XLEN-1:0] src;
  logic [XLEN-1:0] new_val;
  logic            wr;

  always_comb begin
    o_old     = '0;
    o_addr_ok = 1'b1;
    case (i_csr_addr)
      CSR_MSTATUS: o_old = mstatus;
      CSR_MTVEC:   o_old = mtvec;
      CSR_MEPC:    o_old = mepc;
      CSR_MCAUSE:  o_old = mcause;
      default:     o_addr_ok = 1'b0;
    endcase
  end

  assign src = i_csr_imm ? {{(XLEN-5){1'b0}}, i_zimm} : i_rs1data;

  // i_zimm carries the rs1 number in the register forms
  // a zero number blocks the write for set and clear
  always_comb begin
    new_val = src;
    wr      = 1'b0;
    case (i_csr_op)
      CSR_OP_RW: wr = 1'b1;
      CSR_OP_RS: begin
        new_val = o_old | src;
        wr      = (i_zimm != 5'd0);
      end
      CSR_OP_RC: begin
        new_val = o_old & ~src;
        wr      = (i_zimm != 5'd0);
      end
      default: wr = 1'b0;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else if (i_we && wr) begin
      case (i_csr_addr)
        CSR_MSTATUS: mstatus <= new_val;
        CSR_MTVEC:   mtvec   <= new_val;
        CSR_MEPC:    mepc    <= new_val;
        CSR_MCAUSE:  mcause  <= new_val;
        default:     mstatus <= mstatus;
      endcase
    end
  end

  // the caller must filter out unknown addresses before enabling a write
  a_write_addr_known: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_we && wr) |-> o_addr_ok)
    else $error("CSR write enabled for an unknown address");

endmodule

// ==== verilog/rv_alu.sv ====
// 64-bit ALU with 32-bit word mode and sign-extended word results
`timescale 1ns/100ps

module rv_alu (
  input  logic [rv_exec_pkg::XLEN-1:0] i_src_a,
  input  logic [rv_exec_pkg::XLEN-1:0] i_src_b,
  input  rv_exec_pkg::alu_op_e         i_alu_op,
  input  logic                         i_word_cut,
  output logic [rv_exec_pkg::XLEN-1:0] o_result
);
  import rv_exec_pkg::*;

  logic [5:0]      shamt;
  logic [XLEN-1:0] sra_src;
  logic            lt_s;
  logic            lt_u;
  logic [XLEN-1:0] raw;

  // word shifts use 5 bits of amount
  assign shamt = i_word_cut ? {1'b0, i_src_b[4:0]} : i_src_b[5:0];
  // sraw shifts in bit 31 rather than bit 63
  assign sra_src = i_word_cut ? {{(XLEN-32){i_src_a[31]}}, i_src_a[31:0]} : i_src_a;

  assign lt_s = $signed(i_src_a) < $signed(i_src_b);
  assign lt_u = i_src_a < i_src_b;

  always_comb begin
    case (i_alu_op)
      ALU_ADD:    raw = i_src_a + i_src_b;
      ALU_SUB:    raw = i_src_a - i_src_b;
      ALU_SLL:    raw = i_src_a << shamt;
      ALU_SLT:    raw = {{(XLEN-1){1'b0}}, lt_s};
      ALU_SLTU:   raw = {{(XLEN-1){1'b0}}, lt_u};
      ALU_XOR:    raw = i_src_a ^ i_src_b;
      ALU_SRL:    raw = i_src_a >> shamt;
      ALU_SRA:    raw = $signed(sra_src) >>> shamt;
      ALU_OR:     raw = i_src_a | i_src_b;
      ALU_AND:    raw = i_src_a & i_src_b;
      ALU_PASS_B: raw = i_src_b;
      default:    raw = '0;
    endcase
  end

  assign o_result = i_word_cut ? {{(XLEN-32){raw[31]}}, raw[31:0]} : raw;

endmodule

// ==== verilog/rv_gpr_file.sv ====
// general register file, 32 x 64 bit, two read ports, x0 reads zero
`timescale 1ns/100ps

module rv_gpr_file (
  input  logic                         i_clk,
  input  logic                         i_rst_n,
  input  logic [4:0]                   i_raddr1,
  input  logic [4:0]                   i_raddr2,
  output logic [rv_exec_pkg::XLEN-1:0] o_rdata1,
  output logic [rv_exec_pkg::XLEN-1:0] o_rdata2,
  input  logic                         i_we,
  input  logic [4:0]                   i_waddr,
  input  logic [rv_exec_pkg::XLEN-1:0] i_wdata
);
  import rv_exec_pkg::*;

  // x0 has no storage
  logic [XLEN-1:0] regs [1:31];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && i_waddr != 5'd0) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  assign o_rdata1 = (i_raddr1 == 5'd0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == 5'd0) ? '0 : regs[i_raddr2];

endmodule

// ==== verilog/rv_decoder.sv ====
// instruction decoder for immediates, register numbers, control fields and illegal detection
`timescale 1ns/100ps

module rv_decoder (
  input  logic [31:0] i_inst,
  input  logic        i_valid,
  output logic [4:0]  o_rs1,
  output logic [4:0]  o_rs2,
  rv_ctrl_if.dec      ctrl
);
  import rv_exec_pkg::*;

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic            f7_ok;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;

  function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign imm_i = {{(XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{(XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{(XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                  i_inst[30:21], 1'b0};

  // funct7 may only select sub or sra
  assign f7_ok = (funct7 == 7'b0) ||
                 (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));

  assign o_rs1         = i_inst[19:15];
  assign o_rs2         = i_inst[24:20];
  assign ctrl.valid    = i_valid;
  assign ctrl.rd       = i_inst[11:7];
  assign ctrl.csr_addr = i_inst[31:20];

  always_comb begin
    ctrl.src1_pc  = 1'b0;
    ctrl.src2_sel = SRC2_RS2;
    ctrl.alu_op   = ALU_ADD;
    ctrl.word_cut = 1'b0;
    ctrl.csr_op   = CSR_OP_NONE;
    ctrl.csr_imm  = 1'b0;
    ctrl.imm      = imm_i;
    ctrl.rd_we    = 1'b1;
    ctrl.ebreak   = 1'b0;
    ctrl.illegal  = 1'b0;
    case (opcode)
      OPC_OP, OPC_OP_32: begin
        ctrl.word_cut = (opcode == OPC_OP_32);
        ctrl.alu_op   = alu_from_f3(funct3, funct7[5]);
        ctrl.illegal  = !f7_ok ||
                        (ctrl.word_cut && !(funct3 inside {3'b000, 3'b001, 3'b101}));
      end
      OPC_OP_IMM: begin
        ctrl.src2_sel = SRC2_IMM;
        ctrl.alu_op   = alu_from_f3(funct3, funct3 == 3'b101 && i_inst[30]);
        // 6-bit shift amount leaves only inst[31:26] as the funct field
        if (funct3 == 3'b001) begin
          ctrl.illegal = (i_inst[31:26] != 6'b0);
        end else if (funct3 == 3'b101) begin
          ctrl.illegal = !(i_inst[31:26] inside {6'b000000, 6'b010000});
        end
      end
      OPC_OP_IMM_32: begin
        ctrl.src2_sel = SRC2_IMM;
        ctrl.word_cut = 1'b1;
        ctrl.alu_op   = alu_from_f3(funct3, funct3 == 3'b101 && i_inst[30]);
        ctrl.illegal  = !(funct3 == 3'b000 || (funct3 == 3'b001 && funct7 == 7'b0) ||
                          (funct3 == 3'b101 && f7_ok));
      end
      OPC_LUI: begin
        ctrl.src2_sel = SRC2_IMM;
        ctrl.alu_op   = ALU_PASS_B;
        ctrl.imm      = imm_u;
      end
      OPC_AUIPC: begin
        ctrl.src1_pc  = 1'b1;
        ctrl.src2_sel = SRC2_IMM;
        ctrl.imm      = imm_u;
      end
      OPC_JAL: begin
        ctrl.src1_pc  = 1'b1;
        ctrl.src2_sel = SRC2_FOUR;
        ctrl.imm      = imm_j;
      end
      OPC_JALR: begin
        ctrl.src1_pc  = 1'b1;
        ctrl.src2_sel = SRC2_FOUR;
        ctrl.illegal  = (funct3 != 3'b000);
      end
      OPC_SYSTEM: begin
        ctrl.imm     = {{(XLEN-5){1'b0}}, i_inst[19:15]};
        ctrl.csr_imm = funct3[2];
        case (funct3[1:0])
          2'b01:   ctrl.csr_op = CSR_OP_RW;
          2'b10:   ctrl.csr_op = CSR_OP_RS;
          2'b11:   ctrl.csr_op = CSR_OP_RC;
          default: ctrl.csr_op = CSR_OP_NONE;
        endcase
        if (funct3 == 3'b000) begin
          ctrl.rd_we   = 1'b0;
          ctrl.ebreak  = (i_inst == 32'h0010_0073);
          ctrl.illegal = (i_inst != 32'h0010_0073);
        end else if (funct3 == 3'b100) begin
          ctrl.illegal = 1'b1;
        end
      end
      default: ctrl.illegal = 1'b1;
    endcase
  end

endmodule

// ==== verilog/rv_ctrl_if.sv ====
// decoded control bundle from decoder to execute unit
`timescale 1ns/100ps

interface rv_ctrl_if;
  import rv_exec_pkg::*;

  logic            valid;
  logic            src1_pc;
  src2_sel_e       src2_sel;
  alu_op_e         alu_op;
  logic            word_cut;
  csr_op_e         csr_op;
  logic            csr_imm;
  logic [11:0]     csr_addr;
  // for CSR instructions this carries the zero-extended rs1 field
  logic [XLEN-1:0] imm;
  logic [4:0]      rd;
  logic            rd_we;
  logic            ebreak;
  logic            illegal;

  modport dec (
    output valid, src1_pc, src2_sel, alu_op, word_cut, csr_op, csr_imm, csr_addr,
    output imm, rd, rd_we, ebreak, illegal
  );

  modport exu (
    input valid, src1_pc, src2_sel, alu_op, word_cut, csr_op, csr_imm, csr_addr,
    input imm, rd, rd_we, ebreak, illegal
  );

endinterface

// ==== verilog/rv_exec_pkg.sv ====
// data width, ALU/operand/CSR enumerations, major opcodes and machine CSR addresses
package rv_exec_pkg;

  localparam int XLEN = 64;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {
    SRC2_RS2,
    SRC2_IMM,
    SRC2_FOUR
  } src2_sel_e;

  // immediate forms are marked by a separate flag
  typedef enum logic [2:0] {
    CSR_OP_NONE,
    CSR_OP_RW,
    CSR_OP_RS,
    CSR_OP_RC
  } csr_op_e;

  localparam logic [11:0] CSR_MSTATUS = 12'h300;
  localparam logic [11:0] CSR_MTVEC   = 12'h305;
  localparam logic [11:0] CSR_MEPC    = 12'h341;
  localparam logic [11:0] CSR_MCAUSE  = 12'h342;

  localparam logic [6:0] OPC_OP        = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_OP_32     = 7'b0111011;
  localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
  localparam logic [6:0] OPC_LUI       = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
  localparam logic [6:0] OPC_JAL       = 7'b1101111;
  localparam logic [6:0] OPC_JALR      = 7'b1100111;
  localparam logic [6:0] OPC_SYSTEM    = 7'b1110011;

endpackage
